/* coreDefs.sv */
// Shared definitions for the core, the RTL and the testbench
// Instruction fields, opcode values and the ALU operation type

package coreDefs;

	localparam int DataWidth = 32;
	localparam int RegCount = 16;
	localparam int RegIdWidth = 4;

	// Instruction fields
	localparam int OpcodeLsb = 28;
	localparam int OpcodeWidth = 4;
	localparam int RdLsb = 24;
	localparam int RsLsb = 20;
	localparam int RtLsb = 16;
	localparam int ImmWidth = 16; // Low bits, sign-extended

	localparam logic [OpcodeWidth-1:0] OpAdd = 4'h0;
	localparam logic [OpcodeWidth-1:0] OpSub = 4'h1;
	localparam logic [OpcodeWidth-1:0] OpAnd = 4'h2;
	localparam logic [OpcodeWidth-1:0] OpOr = 4'h3;
	localparam logic [OpcodeWidth-1:0] OpXor = 4'h4;
	localparam logic [OpcodeWidth-1:0] OpAddi = 4'h5;
	localparam logic [OpcodeWidth-1:0] OpLd = 4'h6;
	localparam logic [OpcodeWidth-1:0] OpSt = 4'h7;
	localparam logic [OpcodeWidth-1:0] OpBeq = 4'h8;
	localparam logic [OpcodeWidth-1:0] OpHalt = 4'hF;

	// ADD r0,r0,r0 doubles as the bubble
	localparam logic [DataWidth-1:0] NopWord = '0;

	typedef enum logic [2:0] {
		AluAdd,
		AluSub,
		AluAnd,
		AluOr,
		AluXor,
		AluPassB
	} AluOp;

endpackage

/* instrDecoder.sv */
// Instruction decoder for the ID stage
// Pure combinational, splits one word into fields and control flags

`timescale 1ns/1ps

module instrDecoder import coreDefs::*; (
	input  logic [DataWidth-1:0]  instr,
	output logic [RegIdWidth-1:0] rd,
	output logic [RegIdWidth-1:0] rs,
	output logic [RegIdWidth-1:0] rt,
	output logic [DataWidth-1:0]  imm,
	output AluOp                  aluOp,
	output logic                  writesReg,
	output logic                  isLoad,
	output logic                  isStore,
	output logic                  isBranch,
	output logic                  isHalt,
	output logic                  useImm
);

	logic [OpcodeWidth-1:0] opcode;

	assign opcode = instr[OpcodeLsb +: OpcodeWidth];
	assign rd = instr[RdLsb +: RegIdWidth];
	assign rs = instr[RsLsb +: RegIdWidth];
	assign imm = {{(DataWidth-ImmWidth){instr[ImmWidth-1]}}, instr[ImmWidth-1:0]};

	assign writesReg = opcode inside {OpAdd, OpSub, OpAnd, OpOr, OpXor, OpAddi, OpLd};
	assign isLoad = (opcode == OpLd);
	assign isStore = (opcode == OpSt);
	assign isBranch = (opcode == OpBeq);
	assign isHalt = (opcode == OpHalt);
	assign useImm = opcode inside {OpAddi, OpLd, OpSt}; // Address or addend from imm

	// Store data and compare operand both live in the rd field
	assign rt = (isStore || isBranch) ? rd : instr[RtLsb +: RegIdWidth];

	always_comb
	begin
		case (opcode)
			OpSub, OpBeq: aluOp = AluSub;
			OpAnd:        aluOp = AluAnd;
			OpOr:         aluOp = AluOr;
			OpXor:        aluOp = AluXor;
			OpHalt:       aluOp = AluPassB; // Result never written
			default:      aluOp = AluAdd;   // ADD, ADDI, LD, ST and unknown
		endcase
	end

endmodule

/* regFile.sv */
// Register file, 16 words, two read ports and one write port
// A write in the same cycle is visible on the read ports

`timescale 1ns/1ps

module regFile import coreDefs::*; (
	input  logic                  clock,
	input  logic                  reset,
	input  logic [RegIdWidth-1:0] readIdA,
	input  logic [RegIdWidth-1:0] readIdB,
	output logic [DataWidth-1:0]  readDataA,
	output logic [DataWidth-1:0]  readDataB,
	input  logic [RegIdWidth-1:0] writeId,
	input  logic [DataWidth-1:0]  writeData,
	input  logic                  writeEnable
);

	logic [DataWidth-1:0] regs [RegCount];

	function automatic logic [DataWidth-1:0] readReg(input logic [RegIdWidth-1:0] id);
		if (id == '0)
			return '0; // r0 is hardwired
		if (writeEnable && (writeId == id))
			return writeData; // Bypass from EX2
		return regs[id];
	endfunction

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			for (int i = 0; i < RegCount; i++)
				regs[i] <= '0;
		end
		else if (writeEnable)
			regs[writeId] <= writeData;
	end

	always_comb
	begin
		readDataA = readReg(readIdA);
		readDataB = readReg(readIdB);
	end

endmodule

/* aluUnit.sv */
// Integer ALU used in EX1
// Also forms load/store addresses and the BEQ compare

`timescale 1ns/1ps

module aluUnit import coreDefs::*; (
	input  logic [DataWidth-1:0] operandA,
	input  logic [DataWidth-1:0] operandB,
	input  AluOp                 aluOp,
	output logic [DataWidth-1:0] result,
	output logic                 equal
);

	always_comb
	begin
		case (aluOp)
			AluAdd:   result = operandA + operandB;
			AluSub:   result = operandA - operandB;
			AluAnd:   result = operandA & operandB;
			AluOr:    result = operandA | operandB;
			AluXor:   result = operandA ^ operandB;
			AluPassB: result = operandB;
			default:  result = operandA + operandB;
		endcase
	end

	// BEQ compares rs against rd, independent of the op
	assign equal = (operandA == operandB);

endmodule

/* execUnit.sv */
// Four-stage pipeline IF, ID, EX1, EX2 with hold, interlock and branch flush
// Talks to memory through separate fetch and data request ports

`timescale 1ns/1ps

module execUnit import coreDefs::*; #(
	parameter logic [DataWidth-1:0] ResetPc = '0
) (
	input  logic                 clock,
	input  logic                 reset,
	output logic [DataWidth-1:0] fetchAddr,
	output logic                 fetchReq,
	input  logic [DataWidth-1:0] fetchData,
	input  logic                 fetchReady,
	output logic [DataWidth-1:0] dataAddr,
	output logic [DataWidth-1:0] dataWriteData,
	output logic                 dataRead,
	output logic                 dataWrite,
	input  logic [DataWidth-1:0] dataReadData,
	input  logic                 dataReady,
	output logic                 halted
);

	logic [DataWidth-1:0] pc;
	logic [DataWidth-1:0] nextPc;
	logic fetchGot; // Word arrived while IF was held
	logic [DataWidth-1:0] fetchBuf;
	logic [DataWidth-1:0] ifWord;

	logic idValid;
	logic [DataWidth-1:0] idPc;
	logic [DataWidth-1:0] idInstr;
	logic [RegIdWidth-1:0] idRd;
	logic [RegIdWidth-1:0] idRs;
	logic [RegIdWidth-1:0] idRt;
	logic [DataWidth-1:0] idImm;
	logic [DataWidth-1:0] idValA;
	logic [DataWidth-1:0] idValB;
	AluOp idAluOp;
	logic idWritesReg;
	logic idIsLoad;
	logic idIsStore;
	logic idIsBranch;
	logic idIsHalt;
	logic idUseImm;

	logic ex1Valid;
	logic [DataWidth-1:0] ex1Pc;
	logic [RegIdWidth-1:0] ex1Rd;
	logic [DataWidth-1:0] ex1Imm;
	logic [DataWidth-1:0] ex1ValA;
	logic [DataWidth-1:0] ex1ValB;
	AluOp ex1AluOp;
	logic ex1WritesReg;
	logic ex1IsLoad;
	logic ex1IsStore;
	logic ex1IsBranch;
	logic ex1IsHalt;
	logic ex1UseImm;
	logic [DataWidth-1:0] aluResult;
	logic aluEqual;

	logic ex2Valid;
	logic [RegIdWidth-1:0] ex2Rd;
	logic ex2WritesReg;
	logic ex2IsLoad;
	logic ex2IsStore;
	logic [DataWidth-1:0] ex2Result;
	logic [DataWidth-1:0] ex2StoreData;
	logic dataGot; // Data phase done, waiting on a fetch
	logic [DataWidth-1:0] dataBuf;
	logic [DataWidth-1:0] writeValue;
	logic writeEnable;

	logic fetchWait;
	logic dataWait;
	logic globalHold;
	logic interlock;
	logic frontAdvance;
	logic branchTaken;
	logic [1:0] flushMask; // Bit 1 kills IF, bit 0 kills ID
	logic haltEnter;

	instrDecoder decoder (
		.instr(idInstr), .rd(idRd), .rs(idRs), .rt(idRt), .imm(idImm), .aluOp(idAluOp),
		.writesReg(idWritesReg), .isLoad(idIsLoad), .isStore(idIsStore),
		.isBranch(idIsBranch), .isHalt(idIsHalt), .useImm(idUseImm)
	);

	regFile regs (
		.clock(clock), .reset(reset), .readIdA(idRs), .readIdB(idRt),
		.readDataA(idValA), .readDataB(idValB), .writeId(ex2Rd),
		.writeData(writeValue), .writeEnable(writeEnable)
	);

	aluUnit alu (
		.operandA(ex1ValA), .operandB(ex1UseImm ? ex1Imm : ex1ValB), .aluOp(ex1AluOp),
		.result(aluResult), .equal(aluEqual)
	);

	assign ifWord = fetchGot ? fetchBuf : fetchData;
	assign fetchWait = !fetchGot && !fetchReady;
	assign dataWait = ex2Valid && (ex2IsLoad || ex2IsStore) && !dataGot && !dataReady;
	assign globalHold = halted || fetchWait || dataWait; // Freezes every stage

	// BEQ writes no register, so a taken branch never meets the interlock
	assign interlock = idValid && ex1Valid && ex1WritesReg && (ex1Rd != '0) &&
		((idRs == ex1Rd) || (idRt == ex1Rd));
	assign frontAdvance = !globalHold && !interlock;
	assign branchTaken = ex1Valid && ex1IsBranch && aluEqual;
	assign flushMask = {2{branchTaken}};
	assign nextPc = branchTaken ? ex1Pc + (ex1Imm << 2) : pc + 4;
	assign haltEnter = ex1Valid && ex1IsHalt && !globalHold;

	assign writeValue = !ex2IsLoad ? ex2Result : (dataGot ? dataBuf : dataReadData);
	assign writeEnable = ex2Valid && ex2WritesReg && !globalHold;
	assign fetchAddr = pc;
	assign dataAddr = ex2Result;
	assign dataWriteData = ex2StoreData;

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			pc <= ResetPc;
			fetchReq <= 1'b0;
			fetchGot <= 1'b0;
			idValid <= 1'b0;
			ex1Valid <= 1'b0;
			ex2Valid <= 1'b0;
			dataRead <= 1'b0;
			dataWrite <= 1'b0;
			dataGot <= 1'b0;
			halted <= 1'b0;
		end
		else
		begin
			halted <= halted || haltEnter;
			if (frontAdvance)
			begin
				pc <= nextPc;
				idValid <= !flushMask[1];
			end
			if (haltEnter || halted)
				fetchReq <= 1'b0; // No fetch after HALT
			else if (frontAdvance)
				fetchReq <= 1'b1; // Next PC goes out next cycle
			else if (fetchReady)
				fetchReq <= 1'b0;
			else if (!fetchGot)
				fetchReq <= 1'b1;
			if (frontAdvance)
				fetchGot <= 1'b0;
			else if (fetchReady)
				fetchGot <= 1'b1;
			if (!globalHold)
			begin
				ex1Valid <= idValid && !interlock && !flushMask[0]; // Bubble or flush
				ex2Valid <= ex1Valid;
				dataRead <= ex1Valid && ex1IsLoad;
				dataWrite <= ex1Valid && ex1IsStore;
				dataGot <= 1'b0;
			end
			else if (dataReady)
			begin
				dataRead <= 1'b0;
				dataWrite <= 1'b0;
				dataGot <= 1'b1;
			end
		end
	end

	always_ff @(posedge clock)
	begin
		if (fetchReady)
			fetchBuf <= fetchData;
		if (dataReady)
			dataBuf <= dataReadData;
		if (frontAdvance)
		begin
			idInstr <= ifWord;
			idPc <= pc;
		end
		if (!globalHold)
		begin
			ex1Pc <= idPc;
			ex1Rd <= idRd;
			ex1Imm <= idImm;
			ex1ValA <= idValA;
			ex1ValB <= idValB;
			ex1AluOp <= idAluOp;
			ex1WritesReg <= idWritesReg;
			ex1IsLoad <= idIsLoad;
			ex1IsStore <= idIsStore;
			ex1IsBranch <= idIsBranch;
			ex1IsHalt <= idIsHalt;
			ex1UseImm <= idUseImm;
			ex2Rd <= ex1Rd;
			ex2WritesReg <= ex1WritesReg;
			ex2IsLoad <= ex1IsLoad;
			ex2IsStore <= ex1IsStore;
			ex2Result <= aluResult; // ALU value or address
			ex2StoreData <= ex1ValB;
		end
	end

endmodule

/* memArbiter.sv */
// Shares the external memory bus between instruction fetch and data access
// Data wins a tie, and an open request keeps the bus until memReady

`timescale 1ns/1ps

module memArbiter import coreDefs::*; (
	input  logic                 clock,
	input  logic                 reset,
	input  logic [DataWidth-1:0] fetchAddr,
	input  logic                 fetchReq,
	output logic [DataWidth-1:0] fetchData,
	output logic                 fetchReady,
	input  logic [DataWidth-1:0] dataAddr,
	input  logic [DataWidth-1:0] dataWriteData,
	input  logic                 dataRead,
	input  logic                 dataWrite,
	output logic [DataWidth-1:0] dataReadData,
	output logic                 dataReady,
	output logic [DataWidth-1:0] memAddr,
	output logic [DataWidth-1:0] memWriteData,
	output logic                 memRead,
	output logic                 memWrite,
	input  logic [DataWidth-1:0] memReadData,
	input  logic                 memReady
);

	logic busy;      // Request open on the bus
	logic grantData; // Owner of the open request
	logic dataReq;
	logic pickData;

	assign dataReq = dataRead || dataWrite;
	assign pickData = busy ? grantData : dataReq; // Locked while busy

	assign memAddr = pickData ? dataAddr : fetchAddr;
	assign memWriteData = dataWriteData;
	assign memRead = pickData ? dataRead : fetchReq;
	assign memWrite = pickData && dataWrite;

	// Read data is shared, only the owner sees ready
	assign fetchReady = memReady && !pickData;
	assign dataReady = memReady && pickData;
	assign fetchData = memReadData;
	assign dataReadData = memReadData;

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			busy <= 1'b0;
			grantData <= 1'b0;
		end
		else
		begin
			busy <= (memRead || memWrite) && !memReady;
			grantData <= pickData;
		end
	end

endmodule

/* coreTop.sv */
// Core top level, pipeline plus bus arbiter on one external memory bus
// ResetPc sets the first fetch address

`timescale 1ns/1ps

module coreTop import coreDefs::*; #(
	parameter logic [DataWidth-1:0] ResetPc = '0
) (
	input  logic                 clock,
	input  logic                 reset,
	output logic [DataWidth-1:0] memAddr,
	output logic [DataWidth-1:0] memWriteData,
	output logic                 memRead,
	output logic                 memWrite,
	input  logic [DataWidth-1:0] memReadData,
	input  logic                 memReady,
	output logic                 halted
);

	logic [DataWidth-1:0] fetchAddr;
	logic fetchReq;
	logic [DataWidth-1:0] fetchData;
	logic fetchReady;
	logic [DataWidth-1:0] dataAddr;
	logic [DataWidth-1:0] dataWriteData;
	logic dataRead;
	logic dataWrite;
	logic [DataWidth-1:0] dataReadData;
	logic dataReady;

	execUnit #(.ResetPc(ResetPc)) core (
		.clock(clock), .reset(reset),
		.fetchAddr(fetchAddr), .fetchReq(fetchReq),
		.fetchData(fetchData), .fetchReady(fetchReady),
		.dataAddr(dataAddr), .dataWriteData(dataWriteData),
		.dataRead(dataRead), .dataWrite(dataWrite),
		.dataReadData(dataReadData), .dataReady(dataReady),
		.halted(halted)
	);

	memArbiter arbiter (
		.clock(clock), .reset(reset),
		.fetchAddr(fetchAddr), .fetchReq(fetchReq),
		.fetchData(fetchData), .fetchReady(fetchReady),
		.dataAddr(dataAddr), .dataWriteData(dataWriteData),
		.dataRead(dataRead), .dataWrite(dataWrite),
		.dataReadData(dataReadData), .dataReady(dataReady),
		.memAddr(memAddr), .memWriteData(memWriteData),
		.memRead(memRead), .memWrite(memWrite),
		.memReadData(memReadData), .memReady(memReady)
	);

endmodule

/* core_props.sv */
// Bus protocol rules on the external memory bus
// Bound into memArbiter by the testbench

`timescale 1ns/1ps

module coreProps import coreDefs::*; (
	input logic                 clock,
	input logic                 reset,
	input logic [DataWidth-1:0] memAddr,
	input logic [DataWidth-1:0] memWriteData,
	input logic                 memRead,
	input logic                 memWrite,
	input logic                 memReady
);

	// Read and write are exclusive
	assert property (@(posedge clock) disable iff (reset) !(memRead && memWrite))
		else $error("memRead and memWrite are high together");

	// An open request holds until its ready cycle
	assert property (@(posedge clock) disable iff (reset)
		(memRead || memWrite) && !memReady |=>
		$stable(memRead) && $stable(memWrite) && $stable(memAddr) &&
		(!memWrite || $stable(memWriteData)))
		else $error("Bus request changed before memReady");

	assert property (@(posedge clock) reset |=> !memRead && !memWrite)
		else $error("Bus request raised during reset");

endmodule

bind memArbiter coreProps props (
	.clock(clock), .reset(reset), .memAddr(memAddr), .memWriteData(memWriteData),
	.memRead(memRead), .memWrite(memWrite), .memReady(memReady)
);

/* coreTb.sv */
// Testbench for coreTop with a word memory model and random wait states
// Program image and expected stores are read from programPatterns.txt

`timescale 1ns/1ps

module coreTb import coreDefs::*; ();

	localparam logic [DataWidth-1:0] ResetPc = '0;
	localparam int ClockPeriod = 8;
	localparam int ProgramWords = 27;
	localparam logic [7:0] RecordIndex = 8'h40; // Store count, then address and data pairs
	localparam int TimeoutNs = ProgramWords * 4 * 4 * ClockPeriod * 2 + 5 * ClockPeriod;

	logic clock;
	logic reset;
	logic [DataWidth-1:0] memAddr;
	logic [DataWidth-1:0] memWriteData;
	logic memRead;
	logic memWrite;
	logic [DataWidth-1:0] memReadData;
	logic memReady;
	logic halted;

	logic [DataWidth-1:0] image [256]; // Words below 0x40 are the bus memory
	logic [31:0] rngState;
	int waitLeft = 0;
	bit busActive = 1'b0;
	bit firstSeen = 1'b0;
	int resetEdges = 0;
	int storeCount = 0;
	int expectCount = 0;
	int errorCount = 0;

	coreTop #(.ResetPc(ResetPc)) dut (
		.clock(clock), .reset(reset),
		.memAddr(memAddr), .memWriteData(memWriteData),
		.memRead(memRead), .memWrite(memWrite),
		.memReadData(memReadData), .memReady(memReady),
		.halted(halted)
	);

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// Unused locations read back a word that differs for every address
	function automatic logic [DataWidth-1:0] fillWord(input logic [DataWidth-1:0] addr);
		return ~addr ^ {addr[15:0], addr[31:16]} ^ 32'h5A3C96E1;
	endfunction

	function automatic logic [DataWidth-1:0] readWord(input logic [DataWidth-1:0] addr);
		if (addr[31:8] != '0)
			return fillWord(addr);
		return image[{2'b00, addr[7:2]}];
	endfunction

	task automatic checkStore(input logic [DataWidth-1:0] addr, input logic [DataWidth-1:0] data);
		logic [7:0] base;
		string name;
		if (storeCount >= expectCount)
		begin
			$display("Extra store of %h to address %h after all expected stores", data, addr);
			errorCount++;
		end
		else
		begin
			base = RecordIndex + 8'd1 + 8'(2 * storeCount);
			name = $sformatf("store %0d", storeCount);
			if (addr !== image[base])
			begin
				$display("ERROR %s address: expected %h, actual %h", name, image[base], addr);
				errorCount++;
			end
			if (data !== image[base + 8'd1])
			begin
				$display("ERROR %s data: expected %h, actual %h", name, image[base + 8'd1], data);
				errorCount++;
			end
		end
		storeCount++;
	endtask

	initial
	begin
		clock = 1'b0;
		forever #(ClockPeriod / 2) clock = ~clock;
	end

	// Memory model, one request at a time with 0 to 3 wait cycles
	always @(posedge clock)
	begin
		if (reset)
		begin
			memReady <= 1'b0;
			busActive = 1'b0;
			if (resetEdges > 0 && (memRead || memWrite))
			begin
				$display("A bus request was raised while reset was high");
				errorCount++;
			end
			resetEdges++;
		end
		else if (memReady)
		begin
			memReady <= 1'b0; // Request completes on this edge
			busActive = 1'b0;
		end
		else if (memRead || memWrite)
		begin
			if (!busActive)
			begin
				busActive = 1'b1;
				rngState = xorshift(rngState);
				waitLeft = rngState % 4;
				if (halted)
				begin
					$display("A bus request started after halted was raised");
					errorCount++;
				end
				if (!firstSeen)
				begin
					firstSeen = 1'b1;
					if (!memRead)
					begin
						$display("The first bus request after reset is not a read");
						errorCount++;
					end
					if (memAddr !== ResetPc)
					begin
						$display("ERROR first fetch address: expected %h, actual %h", ResetPc,
							memAddr);
						errorCount++;
					end
				end
			end
			if (waitLeft == 0)
			begin
				memReady <= 1'b1;
				if (memWrite)
				begin
					checkStore(memAddr, memWriteData);
					if (memAddr[31:8] == '0)
						image[{2'b00, memAddr[7:2]}] = memWriteData;
				end
				else
					memReadData <= readWord(memAddr);
			end
			else
				waitLeft--;
		end
	end

	initial
	begin
		int failures;
		reset = 1'b1;
		memReady = 1'b0;
		memReadData = '0;
		rngState = 32'd28;
		for (int i = 0; i < 256; i++)
			image[8'(i)] = fillWord(32'(i) << 2);
		$readmemh("programPatterns.txt", image);
		expectCount = image[RecordIndex];
		repeat (5) @(posedge clock);
		reset <= 1'b0;
		while (!halted)
			@(posedge clock);
		repeat (8) @(posedge clock); // Any bus request now is an error
		failures = errorCount;
		if (storeCount < expectCount)
		begin
			$display("Only %0d of %0d expected stores were written", storeCount, expectCount);
			failures++;
		end
		$display("Stores seen %0d of %0d expected, errors %0d", storeCount, expectCount, failures);
		if (failures == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

	initial
	begin
		#(TimeoutNs);
		$display("Timeout after %0d ns without halted", TimeoutNs);
		$display("SIMULATION FAILED");
		$finish;
	end

endmodule

/* programPatterns.txt */
// Hex words for $readmemh and each @ gives the word index of the words after it
// Program from word 0 and LD data at word 30 and the store count at word 40
// Store records follow the count as byte address then data
@00
51000123 5200FFFE 03120000 73000080 // ADDI r1 and ADDI r2 then ADD r3 and ST r3
14120000 74000084 25120000 36120000 // SUB r4 and ST r4 then AND r5 and OR r6
47120000 75000088 7600008C 77000090 // XOR r7 then ST r5 r6 r7
58100010 59800001 0A890000 7A000094 // Dependent chain into r10 then ST r10
5B000060 5C000055 7CB00038 6D0000C0 // Base r11 and data r12 then ST via r11 and LD r13
7D00009C 81100003 710000A0 720000A4 // ST r13 then taken BEQ and two skipped stores
81200002 740000A8 F0000000 00000000 // Not-taken BEQ then ST r4 and HALT
00000000
@30
13579BDF
@40
00000009
00000080 00000121
00000084 00000125
00000088 00000122
0000008C FFFFFFFF
00000090 FFFFFEDD
00000094 00000267
00000098 00000055
0000009C 13579BDF
000000A8 00000125

/* tb.f */
coreDefs.sv
instrDecoder.sv
regFile.sv
aluUnit.sv
execUnit.sv
memArbiter.sv
coreTop.sv
core_props.sv
coreTb.sv

/* Makefile */
LOG = sim.log

.PHONY: help test clean

help:
	@echo "make test   build with Verilator, run and look for the pass message in $(LOG)"
	@echo "make clean  remove obj_dir and $(LOG)"
	@echo "make help   show this list"

test:
	verilator --binary --timing --assert -f tb.f --top-module coreTb -Mdir obj_dir -o coreTb
	./obj_dir/coreTb > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
